// ==== source/sysctl_pkg.sv ====
// shared definitions for the system control block
// holds the widths, the fixed i/o port map and the decode and timer enums
// plus the bit map of port b and port c
package sysctl_pkg;

   // widths
   localparam int IO_ADDR_W = 10;  // isa i/o space
   localparam int DATA_W    = 8;
   localparam int PAGE_W    = 4;   // upper dma address bits a19..a16
   localparam int DMA_CH_W  = 2;

   // fixed system ports
   localparam logic [IO_ADDR_W-1:0] PORT_TIMER2_ADDR     = 10'h042;
   localparam logic [IO_ADDR_W-1:0] PORT_TIMER_CTRL_ADDR = 10'h043;
   localparam logic [IO_ADDR_W-1:0] PORT_B_ADDR          = 10'h061;
   localparam logic [IO_ADDR_W-1:0] PORT_C_ADDR          = 10'h062;
   localparam logic [IO_ADDR_W-1:0] PORT_NMI_ADDR        = 10'h0A0;
   localparam logic [IO_ADDR_W-1:0] PAGE_BASE_ADDR       = 10'h080; // four ports 080..083

   // decoded target of a bus access
   typedef enum logic [2:0] {
      PORT_NONE,
      PORT_TIMER2,
      PORT_TIMER_CTRL,
      PORT_B,
      PORT_C,
      PORT_NMI_MASK,
      PORT_DMA_PAGE
   } io_port_e;

   // which divisor byte the next timer 2 write loads
   typedef enum logic {
      BYTE_LSB,
      BYTE_MSB
   } byte_ptr_e;

   // port b control bits
   localparam int PB_TIMER2_GATE = 0;
   localparam int PB_SPKR_DATA   = 1;
   localparam int PB_PARITY_DIS  = 4; // 1 clears and holds off the parity latch
   localparam int PB_IOCHK_DIS   = 5;

   // port c status bits
   localparam int PC_TIMER2_OUT  = 5;
   localparam int PC_IOCHK       = 6;
   localparam int PC_PARITY      = 7;

   // data bit of a write to the nmi mask port
   localparam int NMI_EN_BIT     = 7;

endpackage

// ==== source/io_bus_ctrl.sv ====
// apb slave front end of the system control block
// decodes the i/o address into a port select and owns the port b register
// writes go out to the other blocks as a one cycle strobe with port and data
// reads return port b or the port c status and 0 for write-only ports
module io_bus_ctrl (
   input  logic                            clk,
   input  logic                            reset_n,
   input  logic                            psel_i,
   input  logic                            penable_i,
   input  logic                            pwrite_i,
   input  logic [sysctl_pkg::IO_ADDR_W-1:0] paddr_i,
   input  logic [sysctl_pkg::DATA_W-1:0]    pwdata_i,
   input  logic                            parity_chk_i,
   input  logic                            io_chk_i,
   input  logic                            timer2_out_i,
   output logic [sysctl_pkg::DATA_W-1:0]    prdata_o,
   output logic                            pready_o,
   output logic                            pslverr_o,
   output logic                            wr_stb_o,
   output sysctl_pkg::io_port_e            wr_port_o,
   output logic [1:0]                      wr_addr_lo_o,
   output logic [sysctl_pkg::DATA_W-1:0]    wr_data_o,
   output logic                            timer2_gate_o,
   output logic                            spkr_data_o,
   output logic                            parity_dis_o,
   output logic                            iochk_dis_o
);
   import sysctl_pkg::*;

   io_port_e          port_sel;
   logic              access;      // second cycle of a transfer
   logic              wr_stb;
   logic [DATA_W-1:0] port_b_q;
   logic [DATA_W-1:0] port_c;
   logic [DATA_W-1:0] rd_data;

   // fixed port decode
   always_comb begin
      if (paddr_i == PORT_TIMER2_ADDR) begin
         port_sel = PORT_TIMER2;
      end else if (paddr_i == PORT_TIMER_CTRL_ADDR) begin
         port_sel = PORT_TIMER_CTRL;
      end else if (paddr_i == PORT_B_ADDR) begin
         port_sel = PORT_B;
      end else if (paddr_i == PORT_C_ADDR) begin
         port_sel = PORT_C;
      end else if (paddr_i == PORT_NMI_ADDR) begin
         port_sel = PORT_NMI_MASK;
      end else if (paddr_i[IO_ADDR_W-1:2] == PAGE_BASE_ADDR[IO_ADDR_W-1:2]) begin
         port_sel = PORT_DMA_PAGE; // low two bits pick the page register
      end else begin
         port_sel = PORT_NONE;
      end
   end

   assign access = psel_i & penable_i;
   assign wr_stb = access & pwrite_i;

   // zero wait states
   assign pready_o  = access;
   assign pslverr_o = access & (port_sel == PORT_NONE);

   // port b register
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         port_b_q <= '0;
      end else if (wr_stb && port_sel == PORT_B) begin
         port_b_q <= pwdata_i;
      end
   end

   assign timer2_gate_o = port_b_q[PB_TIMER2_GATE];
   assign spkr_data_o   = port_b_q[PB_SPKR_DATA];
   assign parity_dis_o  = port_b_q[PB_PARITY_DIS];
   assign iochk_dis_o   = port_b_q[PB_IOCHK_DIS];

   // port c status
   always_comb begin
      port_c                = '0;  // low bits unused here
      port_c[PC_TIMER2_OUT] = timer2_out_i;
      port_c[PC_IOCHK]      = io_chk_i;
      port_c[PC_PARITY]     = parity_chk_i;
   end

   // read mux
   always_comb begin
      case (port_sel)
         PORT_B:  rd_data = port_b_q;
         PORT_C:  rd_data = port_c;
         default: rd_data = '0;  // write-only or unmapped
      endcase
   end

   assign prdata_o = rd_data;

   // write side to the other blocks
   assign wr_stb_o     = wr_stb;
   assign wr_port_o    = port_sel;
   assign wr_addr_lo_o = paddr_i[1:0];
   assign wr_data_o    = pwdata_i;

   // enable only ever inside a selected transfer
   a_penable_psel: assert property (@(posedge clk) disable iff (!reset_n)
      penable_i |-> psel_i);

endmodule

// ==== source/dma_page_regs.sv ====
// dma page register file in the style of the four-word ls670
// the cpu writes a page per channel through ports 080..083
// the active dma channel picks the page driven on the upper address bits
module dma_page_regs (
   input  logic                           clk,
   input  logic                           reset_n,
   input  logic                           wr_en_i,
   input  logic [sysctl_pkg::DMA_CH_W-1:0] wr_idx_i,
   input  logic [sysctl_pkg::PAGE_W-1:0]   wr_data_i,
   input  logic [sysctl_pkg::DMA_CH_W-1:0] dma_chan_i,
   output logic [sysctl_pkg::PAGE_W-1:0]   dma_page_o
);
   import sysctl_pkg::*;

   localparam int NUM_PAGES = 2 ** DMA_CH_W;

   logic [PAGE_W-1:0] page_q [NUM_PAGES];

   // one register per channel
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < NUM_PAGES; i++) begin
            page_q[i] <= '0;
         end
      end else if (wr_en_i) begin
         page_q[wr_idx_i] <= wr_data_i;
      end
   end

   // read port is purely combinational like the ls670
   assign dma_page_o = page_q[dma_chan_i];

endmodule

// ==== source/nmi_ctrl.sv ====
// nmi generation for the system board
// keeps the nmi mask written at port 0a0 and the parity and i/o channel
// check latches which port b bits 4 and 5 enable and clear
module nmi_ctrl (
   input  logic                         clk,
   input  logic                         reset_n,
   input  logic                         wr_stb_i,
   input  sysctl_pkg::io_port_e         wr_port_i,
   input  logic [sysctl_pkg::DATA_W-1:0] wr_data_i,
   input  logic                         parity_err_i,
   input  logic                         io_ch_ck_i,
   input  logic                         parity_dis_i,
   input  logic                         iochk_dis_i,
   output logic                         parity_chk_o,
   output logic                         io_chk_o,
   output logic                         nmi_o
);
   import sysctl_pkg::*;

   logic nmi_mask_q;
   logic parity_chk_q;
   logic io_chk_q;

   // nmi mask from data bit 7
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         nmi_mask_q <= 1'b0;
      end else if (wr_stb_i && wr_port_i == PORT_NMI_MASK) begin
         nmi_mask_q <= wr_data_i[NMI_EN_BIT];
      end
   end

   // check latches stay set until their disable bit is written
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         parity_chk_q <= 1'b0;
         io_chk_q     <= 1'b0;
      end else begin
         if (parity_dis_i) begin
            parity_chk_q <= 1'b0;
         end else if (parity_err_i) begin
            parity_chk_q <= 1'b1;
         end
         if (iochk_dis_i) begin
            io_chk_q <= 1'b0;
         end else if (io_ch_ck_i) begin
            io_chk_q <= 1'b1;
         end
      end
   end

   assign parity_chk_o = parity_chk_q;
   assign io_chk_o     = io_chk_q;
   assign nmi_o        = nmi_mask_q & (parity_chk_q | io_chk_q);

   // a latch may only come up while port b leaves it enabled
   a_parity_dis: assert property (@(posedge clk) disable iff (!reset_n)
      $rose(parity_chk_q) |-> !$past(parity_dis_i));
   a_iochk_dis: assert property (@(posedge clk) disable iff (!reset_n)
      $rose(io_chk_q) |-> !$past(iochk_dis_i));

endmodule

// ==== source/speaker_timer.sv ====
// timer channel 2 of the 8253 reduced to its square wave mode
// the divisor loads low byte then high byte at port 042 and a write to
// port 043 restarts that order
// output is gated by port b bit 0 and anded with port b bit 1 for the speaker
module speaker_timer #(
   parameter int TIMER_PRESCALE = 4  // clk cycles per timer tick
) (
   input  logic                         clk,
   input  logic                         reset_n,
   input  logic                         wr_stb_i,
   input  sysctl_pkg::io_port_e         wr_port_i,
   input  logic [sysctl_pkg::DATA_W-1:0] wr_data_i,
   input  logic                         gate_i,
   input  logic                         spkr_data_i,
   output logic                         timer2_out_o,
   output logic                         spkr_o
);
   import sysctl_pkg::*;

   localparam int PRESC_W = (TIMER_PRESCALE > 1) ? $clog2(TIMER_PRESCALE) : 1;
   localparam logic [PRESC_W-1:0] PRESC_MAX = PRESC_W'(TIMER_PRESCALE - 1);

   logic [PRESC_W-1:0] presc_q;
   logic               tick;
   byte_ptr_e          byte_ptr_q;
   logic [15:0]        divisor_q;
   logic [15:0]        reload;
   logic [15:0]        count_q;
   logic               out_q;
   logic               spkr_q;

   // prescaler held at zero while the gate is off
   always_ff @(posedge clk) begin
      if (!reset_n || !gate_i) begin
         presc_q <= '0;
      end else if (presc_q == PRESC_MAX) begin
         presc_q <= '0;
      end else begin
         presc_q <= presc_q + 1'b1;
      end
   end

   assign tick = gate_i && (presc_q == PRESC_MAX);

   // divisor load
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         byte_ptr_q <= BYTE_LSB;
         divisor_q  <= '0;
      end else if (wr_stb_i && wr_port_i == PORT_TIMER_CTRL) begin
         byte_ptr_q <= BYTE_LSB;
      end else if (wr_stb_i && wr_port_i == PORT_TIMER2) begin
         if (byte_ptr_q == BYTE_LSB) begin
            divisor_q[7:0] <= wr_data_i;
            byte_ptr_q     <= BYTE_MSB;
         end else begin
            divisor_q[15:8] <= wr_data_i;
            byte_ptr_q      <= BYTE_LSB;
         end
      end
   end

   assign reload = {divisor_q[15:1], 1'b0}; // odd bit dropped in mode 3

   // count by two and toggle once per half period
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         count_q <= '0;
         out_q   <= 1'b1;
      end else if (!gate_i) begin
         count_q <= reload;
         out_q   <= 1'b1;
      end else if (tick) begin
         if (count_q <= 16'd2) begin
            count_q <= reload;   // new divisor picked up here
            out_q   <= ~out_q;
         end else begin
            count_q <= count_q - 16'd2;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         spkr_q <= 1'b0;
      end else begin
         spkr_q <= out_q & spkr_data_i;
      end
   end

   assign timer2_out_o = out_q;
   assign spkr_o       = spkr_q;

   a_presc_range: assert property (@(posedge clk) disable iff (!reset_n)
      int'(presc_q) < TIMER_PRESCALE);

endmodule

// ==== source/sys_ctrl_top.sv ====
// system control logic of the motherboard behind one apb slave
// joins the bus front end with the page registers, the nmi logic and the
// speaker timer
module sys_ctrl_top #(
   parameter int TIMER_PRESCALE = 4
) (
   input  logic                            clk,
   input  logic                            reset_n,
   input  logic                            psel_i,
   input  logic                            penable_i,
   input  logic                            pwrite_i,
   input  logic [sysctl_pkg::IO_ADDR_W-1:0] paddr_i,
   input  logic [sysctl_pkg::DATA_W-1:0]    pwdata_i,
   output logic [sysctl_pkg::DATA_W-1:0]    prdata_o,
   output logic                            pready_o,
   output logic                            pslverr_o,
   input  logic                            parity_err_i,
   input  logic                            io_ch_ck_i,
   input  logic [sysctl_pkg::DMA_CH_W-1:0]  dma_chan_i,
   output logic                            nmi_o,
   output logic [sysctl_pkg::PAGE_W-1:0]    dma_page_o,
   output logic                            spkr_o
);
   import sysctl_pkg::*;

   logic              wr_stb;
   io_port_e          wr_port;
   logic [1:0]        wr_addr_lo;
   logic [DATA_W-1:0] wr_data;
   logic              timer2_gate;
   logic              spkr_data;
   logic              parity_dis;
   logic              iochk_dis;
   logic              parity_chk;
   logic              io_chk;
   logic              timer2_out;
   logic              page_wr_en;

   io_bus_ctrl u_bus (
      .clk           (clk),
      .reset_n       (reset_n),
      .psel_i        (psel_i),
      .penable_i     (penable_i),
      .pwrite_i      (pwrite_i),
      .paddr_i       (paddr_i),
      .pwdata_i      (pwdata_i),
      .parity_chk_i  (parity_chk),
      .io_chk_i      (io_chk),
      .timer2_out_i  (timer2_out),
      .prdata_o      (prdata_o),
      .pready_o      (pready_o),
      .pslverr_o     (pslverr_o),
      .wr_stb_o      (wr_stb),
      .wr_port_o     (wr_port),
      .wr_addr_lo_o  (wr_addr_lo),
      .wr_data_o     (wr_data),
      .timer2_gate_o (timer2_gate),
      .spkr_data_o   (spkr_data),
      .parity_dis_o  (parity_dis),
      .iochk_dis_o   (iochk_dis)
   );

   assign page_wr_en = wr_stb & (wr_port == PORT_DMA_PAGE);

   dma_page_regs u_page (
      .clk        (clk),
      .reset_n    (reset_n),
      .wr_en_i    (page_wr_en),
      .wr_idx_i   (wr_addr_lo),
      .wr_data_i  (wr_data[PAGE_W-1:0]), // page data on the low nibble
      .dma_chan_i (dma_chan_i),
      .dma_page_o (dma_page_o)
   );

   nmi_ctrl u_nmi (
      .clk          (clk),
      .reset_n      (reset_n),
      .wr_stb_i     (wr_stb),
      .wr_port_i    (wr_port),
      .wr_data_i    (wr_data),
      .parity_err_i (parity_err_i),
      .io_ch_ck_i   (io_ch_ck_i),
      .parity_dis_i (parity_dis),
      .iochk_dis_i  (iochk_dis),
      .parity_chk_o (parity_chk),
      .io_chk_o     (io_chk),
      .nmi_o        (nmi_o)
   );

   speaker_timer #(
      .TIMER_PRESCALE (TIMER_PRESCALE)
   ) u_timer (
      .clk          (clk),
      .reset_n      (reset_n),
      .wr_stb_i     (wr_stb),
      .wr_port_i    (wr_port),
      .wr_data_i    (wr_data),
      .gate_i       (timer2_gate),
      .spkr_data_i  (spkr_data),
      .timer2_out_o (timer2_out),
      .spkr_o       (spkr_o)
   );

endmodule

// ==== sim/tb_sys_ctrl.sv ====
// testbench for the system control block
// runs directed tests over the apb port: reset state, decode errors,
// dma page registers, nmi check latches and the speaker tone
// prints the error count and the verdict at the end of the run
module tb_sys_ctrl;
   import sysctl_pkg::*;

   localparam int          TB_PRESCALE = 4;
   localparam int          CLK_HALF    = 2;
   localparam int          MAX_DIV     = 512;
   localparam int          EDGE_WAIT   = 3 * MAX_DIV * TB_PRESCALE + 64; // three tone rises
   localparam int          MAX_CYCLES  = 20000;  // tone test under 8k, the rest a few hundred
   localparam logic [31:0] RAND_SEED   = 32'h90d3_6575;
   localparam logic [7:0]  PC_IDLE     = 8'h20;  // only timer 2 output high

   logic       clk;
   logic       reset_n;
   logic       psel;
   logic       penable;
   logic       pwrite;
   logic [9:0] paddr;
   logic [7:0] pwdata;
   logic [7:0] prdata;
   logic       pready;
   logic       pslverr;
   logic       parity_err;
   logic       io_ch_ck;
   logic [1:0] dma_chan;
   logic       nmi;
   logic [3:0] dma_page;
   logic       spkr;
   int         err_cnt;
   int         cycle_cnt;
   int         seed_val;

   sys_ctrl_top #(.TIMER_PRESCALE(TB_PRESCALE)) UUT (
      .clk          (clk),
      .reset_n      (reset_n),
      .psel_i       (psel),
      .penable_i    (penable),
      .pwrite_i     (pwrite),
      .paddr_i      (paddr),
      .pwdata_i     (pwdata),
      .prdata_o     (prdata),
      .pready_o     (pready),
      .pslverr_o    (pslverr),
      .parity_err_i (parity_err),
      .io_ch_ck_i   (io_ch_ck),
      .dma_chan_i   (dma_chan),
      .nmi_o        (nmi),
      .dma_page_o   (dma_page),
      .spkr_o       (spkr)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   task automatic value_error(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      $display("FAIL at %0t: %s expected %0h got %0h", $time, name, exp, act);
      err_cnt++;
   endtask

   // setup cycle then access cycle, write lands on the edge ending the access
   task automatic apb_write(input logic [9:0] addr, input logic [7:0] data);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      if (pready !== 1'b1) value_error("pready_o", 32'h1, 32'(pready));
      if (pslverr !== 1'b0) value_error($sformatf("pslverr_o @%03h", addr), 32'h0, 32'(pslverr));
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [9:0] addr, output logic [7:0] data, output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      if (pready !== 1'b1) value_error("pready_o", 32'h1, 32'(pready));
      data = prdata;
      err  = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic check_read(input logic [9:0] addr, input logic [7:0] exp_data,
                             input logic exp_err);
      logic [7:0] rdata;
      logic       err;
      apb_read(addr, rdata, err);
      if (rdata !== exp_data) begin
         value_error($sformatf("prdata_o @%03h", addr), 32'(exp_data), 32'(rdata));
      end
      if (err !== exp_err) value_error($sformatf("pslverr_o @%03h", addr), 32'(exp_err), 32'(err));
   endtask

   // one cycle pulse, the latch takes it on the edge in between
   task automatic pulse_checks(input logic par, input logic ioc);
      @(negedge clk);
      parity_err = par;
      io_ch_ck   = ioc;
      @(negedge clk);
      parity_err = 1'b0;
      io_ch_ck   = 1'b0;
   endtask

   task automatic test_reset_state();
      logic [31:0] rnd;
      logic [7:0]  pb_val;
      check_read(PORT_B_ADDR, 8'h00, 1'b0);
      check_read(PORT_C_ADDR, PC_IDLE, 1'b0);
      @(posedge clk);
      if (nmi !== 1'b0) value_error("nmi_o", 32'h0, 32'(nmi));
      if (spkr !== 1'b0) value_error("spkr_o", 32'h0, 32'(spkr));
      rnd    = $urandom;
      pb_val = rnd[7:0];
      apb_write(PORT_B_ADDR, pb_val);
      check_read(PORT_B_ADDR, pb_val, 1'b0);
   endtask

   task automatic test_decode();
      check_read(10'h3FF, 8'h00, 1'b1);
      check_read(10'h060, 8'h00, 1'b1);
      check_read(PORT_TIMER2_ADDR, 8'h00, 1'b0);      // write-only ports
      check_read(PORT_TIMER_CTRL_ADDR, 8'h00, 1'b0);
      check_read(PORT_NMI_ADDR, 8'h00, 1'b0);
      for (int i = 0; i < 4; i++) begin
         check_read(PAGE_BASE_ADDR + {8'd0, i[1:0]}, 8'h00, 1'b0);
      end
   endtask

   task automatic test_dma_pages();
      logic [31:0] rnd;
      logic [3:0]  exp_page [4];
      for (int i = 0; i < 4; i++) begin
         rnd         = $urandom;
         exp_page[i] = rnd[3:0];
         apb_write(PAGE_BASE_ADDR + {8'd0, i[1:0]}, {4'h0, exp_page[i]});
      end
      for (int ch = 0; ch < 4; ch++) begin
         @(negedge clk);
         dma_chan = ch[1:0];
         @(posedge clk);  // combinational path, settled by now
         if (dma_page !== exp_page[ch]) begin
            value_error($sformatf("dma_page_o ch%0d", ch), 32'(exp_page[ch]), 32'(dma_page));
         end
      end
   endtask

   task automatic test_nmi();
      apb_write(PORT_B_ADDR, 8'h00);
      apb_write(PORT_NMI_ADDR, 8'h00);
      pulse_checks(1'b1, 1'b0);
      @(posedge clk);
      if (nmi !== 1'b0) value_error("nmi_o masked", 32'h0, 32'(nmi));
      check_read(PORT_C_ADDR, 8'hA0, 1'b0);
      apb_write(PORT_B_ADDR, 8'h10);  // drop the parity latch again
      apb_write(PORT_B_ADDR, 8'h00);
      check_read(PORT_C_ADDR, PC_IDLE, 1'b0);
      apb_write(PORT_NMI_ADDR, 8'h80);
      @(posedge clk);
      if (nmi !== 1'b0) value_error("nmi_o no check", 32'h0, 32'(nmi));
      pulse_checks(1'b0, 1'b1);
      @(posedge clk);
      if (nmi !== 1'b1) value_error("nmi_o io check", 32'h1, 32'(nmi));
      check_read(PORT_C_ADDR, 8'h60, 1'b0);
      pulse_checks(1'b1, 1'b0);
      check_read(PORT_C_ADDR, 8'hE0, 1'b0);
      apb_write(PORT_B_ADDR, 8'h30);  // both disables
      @(posedge clk);  // latches clear on this edge
      @(negedge clk);
      if (nmi !== 1'b0) value_error("nmi_o cleared", 32'h0, 32'(nmi));
      check_read(PORT_C_ADDR, PC_IDLE, 1'b0);
      pulse_checks(1'b1, 1'b1);
      @(posedge clk);
      if (nmi !== 1'b0) value_error("nmi_o disabled", 32'h0, 32'(nmi));
      check_read(PORT_C_ADDR, PC_IDLE, 1'b0);
   endtask

   // counts cycles between the second and third rise, the first may be startup
   task automatic measure_period(output int period);
      logic prev;
      int   n;
      int   rises;
      int   last;
      prev   = 1'b0;
      n      = 0;
      rises  = 0;
      last   = 0;
      period = -1;
      while (rises < 3 && n < EDGE_WAIT) begin
         @(posedge clk);
         n++;
         if (spkr === 1'b1 && prev === 1'b0) begin
            rises++;
            if (rises == 3) period = n - last;
            last = n;
         end
         prev = spkr;
      end
   endtask

   task automatic test_tone();
      logic [31:0] rnd;
      logic [15:0] divisor;
      int          period;
      logic        seen_high;
      rnd     = $urandom;
      divisor = {7'd0, rnd[7:0], 1'b0} + 16'd2;  // even, 2..512
      apb_write(PORT_TIMER_CTRL_ADDR, 8'h00);
      apb_write(PORT_TIMER2_ADDR, divisor[7:0]);
      apb_write(PORT_TIMER2_ADDR, divisor[15:8]);
      apb_write(PORT_B_ADDR, 8'h03);
      measure_period(period);
      if (period < 0) begin
         $display("spkr_o showed no steady tone within %0d cycles", EDGE_WAIT);
         err_cnt++;
      end else if (period != int'(divisor) * TB_PRESCALE) begin
         value_error("spkr_o period", 32'(int'(divisor) * TB_PRESCALE), 32'(period));
      end
      apb_write(PORT_B_ADDR, 8'h01);
      seen_high = 1'b0;
      @(posedge clk);  // spkr register catches up
      repeat (int'(divisor) * TB_PRESCALE) begin
         @(posedge clk);
         if (spkr !== 1'b0 && !seen_high) begin
            value_error("spkr_o data off", 32'h0, 32'(spkr));
            seen_high = 1'b1;
         end
      end
      apb_write(PORT_B_ADDR, 8'h00);
      check_read(PORT_C_ADDR, PC_IDLE, 1'b0);
   endtask

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
   end

   initial begin
      err_cnt    = 0;
      seed_val   = $urandom(RAND_SEED);
      reset_n    = 1'b0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      parity_err = 1'b0;
      io_ch_ck   = 1'b0;
      dma_chan   = '0;
      repeat (5) @(negedge clk);
      reset_n = 1'b1;
      test_reset_state();
      test_decode();
      test_dma_pages();
      test_nmi();
      test_tone();
      $display("run complete with %0d errors", err_cnt);
      if (err_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
source/sysctl_pkg.sv
source/io_bus_ctrl.sv
source/dma_page_regs.sv
source/nmi_ctrl.sv
source/speaker_timer.sv
source/sys_ctrl_top.sv
sim/tb_sys_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with verilator, run, then scan the log for the fail verdict
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_sys_ctrl -f sources.f
status=0
./obj_dir/Vtb_sys_ctrl > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "TB FAILED" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
echo "simulation finished without failure"
